//--- compile.f
+incdir+.
dma_cmd_pkg.sv
dac_out_pkg.sv
pwl_cmd_sequencer.sv
pwl_lane.sv
dac_batch_packer.sv
pwl_gen_top.sv
tb_clock_gen.sv
pwl_gen_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= pwl_gen_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- pwl_gen_tb.sv
`timescale 1ns/1ps
`include "pwl_defines.svh"

module pwl_gen_tb;

    localparam int MAX_CMDS = 32;
    localparam int SW       = `SAMPLE_WIDTH;
    localparam int BS       = `BATCH_SAMPLES;

    logic                   ps_clk;
    logic                   rst_n;
    dma_cmd_pkg::dma_word_t pwl_tdata;
    logic                   pwl_tvalid;
    logic                   pwl_tlast;
    logic                   pwl_tready;
    logic                   dac0_rdy;
    dac_out_pkg::batch_t    dac_batch;
    logic                   valid_dac_batch;
    logic                   dac_batch_last;

    // command list of the running test
    dma_cmd_pkg::sample_t cmd_x   [MAX_CMDS];
    dma_cmd_pkg::slope_t  cmd_s   [MAX_CMDS];
    dma_cmd_pkg::dt_t     cmd_d   [MAX_CMDS];
    bit                   cmd_l   [MAX_CMDS];
    int                   cmd_gap [MAX_CMDS];

    // model output in command order
    dac_out_pkg::batch_t exp_batch_q [$];
    bit                  exp_last_q  [$];

    integer seed;
    int     rnd_rdy;
    bit     rdy_random;
    string  test_name;
    int     error_count;
    int     check_count;
    int     out_count;

    // batch seen waiting at the previous negedge
    bit                  held_valid;
    dac_out_pkg::batch_t held_batch;
    logic                held_last;

    tb_clock_gen u_clk (
        .ps_clk (ps_clk),
        .rst_n  (rst_n)
    );

    pwl_gen_top UUT (
        .ps_clk          (ps_clk),
        .rst_n           (rst_n),
        .pwl_tdata       (pwl_tdata),
        .pwl_tvalid      (pwl_tvalid),
        .pwl_tlast       (pwl_tlast),
        .pwl_tready      (pwl_tready),
        .dac0_rdy        (dac0_rdy),
        .dac_batch       (dac_batch),
        .valid_dac_batch (valid_dac_batch),
        .dac_batch_last  (dac_batch_last)
    );

    // start plus slope times the global sample index, modulo 2^16
    function automatic dma_cmd_pkg::sample_t model_sample(input dma_cmd_pkg::sample_t x,
                                                          input dma_cmd_pkg::slope_t s,
                                                          input int idx);
        int v;
        v = int'(x) + int'(s) * idx;
        return v[SW-1:0];
    endfunction

    // one expected batch per duration step
    task automatic expand_cmd(input int n);
        dac_out_pkg::batch_t b;
        int dur;
        dur = int'(cmd_d[n]);
        for (int k = 0; k < dur; k++) begin
            for (int i = 0; i < BS; i++) begin
                b[i*SW +: SW] = model_sample(cmd_x[n], cmd_s[n], k * BS + i);
            end
            exp_batch_q.push_back(b);
            exp_last_q.push_back(cmd_l[n] && (k == dur - 1));
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d, batches: %0d, errors: %0d", check_count, out_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        error_count++;
        $display("timeout in %s: %s", test_name, what);
        finish_run();
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge ps_clk);
            #1;
        end
    endtask

    // fills the command list and returns the sum of durations
    task automatic build_cmds(input int n, input int zero_pct, input int max_dt,
                              input bit no_gaps, output int total);
        int rnd;
        int dur;
        total = 0;
        for (int i = 0; i < n; i++) begin
            rnd = $random(seed);
            cmd_x[i] = rnd[15:0];
            cmd_s[i] = rnd[31:16];
            rnd = $random(seed);
            dur = int'(rnd[7:0]) % max_dt + 1;
            if (int'(rnd[15:8]) % 100 < zero_pct) begin
                dur = 0;
            end
            cmd_d[i]   = dma_cmd_pkg::dt_t'(dur);
            cmd_l[i]   = rnd[16];
            cmd_gap[i] = no_gaps ? 0 : int'(rnd[18:17]);
            total += dur;
        end
    endtask

    // entered and left 1 ns after a rising edge
    // valid stays high on return
    task automatic send_cmd(input int n);
        int waited;
        pwl_tdata  = {cmd_d[n], cmd_s[n], cmd_x[n]};
        pwl_tvalid = 1'b1;
        pwl_tlast  = cmd_l[n];
        expand_cmd(n);
        waited = 0;
        @(negedge ps_clk);
        while (!pwl_tready) begin
            waited++;
            if (waited > 2000) begin
                report_timeout("command never accepted");
            end
            @(negedge ps_clk);
        end
        @(posedge ps_clk);
        #1;
    endtask

    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        while (exp_batch_q.size() != 0) begin
            @(posedge ps_clk);
            #1;
            waited++;
            if (waited > limit) begin
                report_timeout("output stalled with batches still expected");
            end
        end
    endtask

    task automatic run_test(input string name, input int n, input int zero_pct,
                            input int max_dt, input bit random_rdy);
        int total;
        int start;
        test_name = name;
        build_cmds(n, zero_pct, max_dt, 1'b0, total);
        start = out_count;
        rdy_random = random_rdy;
        for (int i = 0; i < n; i++) begin
            send_cmd(i);
            if (cmd_gap[i] > 0) begin
                pwl_tvalid = 1'b0;
                pwl_tlast  = 1'b0;
                idle_cycles(cmd_gap[i]);
            end
        end
        pwl_tvalid = 1'b0;
        pwl_tlast  = 1'b0;
        wait_drain(4000);
        rdy_random = 1'b0;
        // let the ready driver settle before the next draw
        idle_cycles(2);
        // no batch beyond the sum of durations
        check_count++;
        assert (out_count - start == total)
        else begin
            error_count++;
            $display("error: %s batch count expected %0d actual %0d", test_name, total,
                     out_count - start);
        end
    endtask

    // DAC ready held high or drawn per cycle
    always @(posedge ps_clk) begin
        #1;
        if (rdy_random) begin
            rnd_rdy  = $random(seed);
            dac0_rdy = rnd_rdy[3];
        end else begin
            dac0_rdy = 1'b1;
        end
    end

    // output monitor samples at the falling edge where all is stable
    always @(negedge ps_clk) begin
        if (!rst_n) begin
            held_valid = 1'b0;
        end else begin
            if (held_valid) begin
                check_count++;
                assert (valid_dac_batch && dac_batch === held_batch
                        && dac_batch_last === held_last)
                else begin
                    error_count++;
                    $display("error: %s held batch expected %h actual %h", test_name,
                             held_batch, dac_batch);
                end
            end
            held_valid = valid_dac_batch && !dac0_rdy;
            held_batch = dac_batch;
            held_last  = dac_batch_last;
            // transfer happens on the coming rising edge
            if (valid_dac_batch && dac0_rdy) begin
                check_count++;
                assert (exp_batch_q.size() != 0)
                else begin
                    error_count++;
                    $display("%s: DAC batch %h appeared with no batch expected", test_name,
                             dac_batch);
                end
                if (exp_batch_q.size() != 0) begin
                    check_count += 2;
                    assert (dac_batch === exp_batch_q[0])
                    else begin
                        error_count++;
                        $display("error: %s batch %0d expected %h actual %h", test_name,
                                 out_count, exp_batch_q[0], dac_batch);
                    end
                    assert (dac_batch_last === exp_last_q[0])
                    else begin
                        error_count++;
                        $display("error: %s last of batch %0d expected %0b actual %0b",
                                 test_name, out_count, exp_last_q[0], dac_batch_last);
                    end
                    void'(exp_batch_q.pop_front());
                    void'(exp_last_q.pop_front());
                end
                out_count++;
            end
        end
    end

    initial begin
        int waited;
        int total;
        int start;
        seed        = 89397;
        error_count = 0;
        check_count = 0;
        out_count   = 0;
        rdy_random  = 1'b0;
        held_valid  = 1'b0;
        pwl_tdata   = '0;
        pwl_tvalid  = 1'b0;
        pwl_tlast   = 1'b0;
        dac0_rdy    = 1'b1;
        test_name   = "reset";

        waited = 0;
        while (rst_n !== 1'b1) begin
            @(posedge ps_clk);
            waited++;
            if (waited > 50) begin
                report_timeout("reset never released");
            end
        end
        // idle after reset with nothing on the DAC port
        @(negedge ps_clk);
        check_count++;
        assert (pwl_tready === 1'b1 && valid_dac_batch === 1'b0 && dac_batch_last === 1'b0)
        else begin
            error_count++;
            $display("error: %s ready/valid/last expected 100 actual %b%b%b", test_name,
                     pwl_tready, valid_dac_batch, dac_batch_last);
        end
        @(posedge ps_clk);
        #1;

        run_test("ready_high", 20, 0, 6, 1'b0);
        run_test("back_pressure", 20, 0, 6, 1'b1);
        run_test("zero_duration", 24, 30, 5, 1'b1);

        // stream always valid and DAC always ready
        test_name = "throughput";
        build_cmds(16, 0, 8, 1'b1, total);
        start = out_count;
        fork
            begin
                for (int i = 0; i < 16; i++) begin
                    send_cmd(i);
                end
                pwl_tvalid = 1'b0;
                pwl_tlast  = 1'b0;
            end
            begin
                waited = 0;
                while (out_count - start < total) begin
                    @(posedge ps_clk);
                    #1;
                    waited++;
                    // accept edge, lane stage and output register, then one batch per clock
                    if (waited > total + 3) begin
                        report_timeout("output stalled");
                    end
                end
            end
        join
        idle_cycles(4);
        check_count++;
        assert (out_count - start == total)
        else begin
            error_count++;
            $display("error: %s batch count expected %0d actual %0d", test_name, total,
                     out_count - start);
        end

        finish_run();
    end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 2,
    parameter int RESET_CYCLES   = 10
) (
    output logic ps_clk,
    output logic rst_n
);

    // 4 ns period
    initial begin
        ps_clk = 1'b0;
        forever #(HALF_PERIOD_NS) ps_clk = ~ps_clk;
    end

    // release lines up with the stimulus offset
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge ps_clk);
        #1 rst_n = 1'b1;
    end

endmodule

//--- pwl_gen_top.sv
`timescale 1ns/1ps
`include "pwl_defines.svh"

module pwl_gen_top (
    input  wire                    ps_clk,
    input  wire                    rst_n,
    // PWL commands from the DMA
    input  dma_cmd_pkg::dma_word_t pwl_tdata,
    input  wire                    pwl_tvalid,
    input  wire                    pwl_tlast,
    output logic                   pwl_tready,
    // DAC port
    input  wire                    dac0_rdy,
    output dac_out_pkg::batch_t    dac_batch,
    output logic                   valid_dac_batch,
    output logic                   dac_batch_last
);

    logic                 advance;

    // sequencer to lanes
    dma_cmd_pkg::sample_t lane_base;
    dma_cmd_pkg::slope_t  lane_slope;
    logic                 lane_in_valid;
    logic                 lane_in_last;

    // lanes to packer
    dac_out_pkg::batch_t          lane_samples;
    logic [`BATCH_SAMPLES-1:0]    lane_out_valid;
    logic [`BATCH_SAMPLES-1:0]    lane_out_last;

    pwl_cmd_sequencer u_sequencer (
        .ps_clk     (ps_clk),
        .rst_n      (rst_n),
        .pwl_tdata  (pwl_tdata),
        .pwl_tvalid (pwl_tvalid),
        .pwl_tlast  (pwl_tlast),
        .pwl_tready (pwl_tready),
        .advance    (advance),
        .lane_base  (lane_base),
        .lane_slope (lane_slope),
        .lane_valid (lane_in_valid),
        .lane_last  (lane_in_last)
    );

    // one lane per sample, lane i lands in slice i of the batch
    for (genvar g = 0; g < `BATCH_SAMPLES; g++) begin : g_lane
        pwl_lane #(.LANE(g)) u_lane (
            .ps_clk    (ps_clk),
            .rst_n     (rst_n),
            .advance   (advance),
            .base      (lane_base),
            .slope     (lane_slope),
            .in_valid  (lane_in_valid),
            .in_last   (lane_in_last),
            .sample    (lane_samples[g*`SAMPLE_WIDTH +: `SAMPLE_WIDTH]),
            .out_valid (lane_out_valid[g]),
            .out_last  (lane_out_last[g])
        );
    end

    // all lanes move together, lane 0 speaks for the batch
    dac_batch_packer u_packer (
        .ps_clk          (ps_clk),
        .rst_n           (rst_n),
        .lane_samples    (lane_samples),
        .lane_valid      (lane_out_valid[0]),
        .lane_last       (lane_out_last[0]),
        .dac0_rdy        (dac0_rdy),
        .advance         (advance),
        .dac_batch       (dac_batch),
        .valid_dac_batch (valid_dac_batch),
        .dac_batch_last  (dac_batch_last)
    );

endmodule

//--- dac_batch_packer.sv
`timescale 1ns/1ps
`include "pwl_defines.svh"

module dac_batch_packer (
    input  wire                 ps_clk,
    input  wire                 rst_n,
    // from the lanes
    input  dac_out_pkg::batch_t lane_samples,
    input  wire                 lane_valid,
    input  wire                 lane_last,
    // DAC side
    input  wire                 dac0_rdy,
    // stall to the whole pipeline
    output logic                advance,
    output dac_out_pkg::batch_t dac_batch,
    output logic                valid_dac_batch,
    output logic                dac_batch_last
);

    // output slot free or being emptied this cycle
    assign advance = !valid_dac_batch || dac0_rdy;

    // handshake flags
    always_ff @(posedge ps_clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_dac_batch <= 1'b0;
            dac_batch_last  <= 1'b0;
        end else if (advance) begin
            valid_dac_batch <= lane_valid;
            // last only ever rides on a real batch
            dac_batch_last  <= lane_valid && lane_last;
        end
    end

    // batch register
    // held while the DAC is not ready
    always_ff @(posedge ps_clk) begin
        if (advance) begin
            dac_batch <= lane_samples;
        end
    end

    // offered batch must not move before the DAC takes it
    a_hold_under_stall : assert property (
        @(posedge ps_clk) disable iff (!rst_n)
        (valid_dac_batch && !dac0_rdy) |=>
            (valid_dac_batch && $stable(dac_batch) && $stable(dac_batch_last))
    );

endmodule

//--- pwl_lane.sv
`timescale 1ns/1ps
`include "pwl_defines.svh"

module pwl_lane #(
    // position of this sample inside the batch
    parameter int LANE = 0
) (
    input  wire                  ps_clk,
    input  wire                  rst_n,
    input  wire                  advance,
    input  dma_cmd_pkg::sample_t base,
    input  dma_cmd_pkg::slope_t  slope,
    input  wire                  in_valid,
    input  wire                  in_last,
    output dma_cmd_pkg::sample_t sample,
    output logic                 out_valid,
    output logic                 out_last
);

    // lane index must fit the batch
    if (LANE < 0 || LANE >= `BATCH_SAMPLES) begin : g_bad_lane
        $error("pwl_lane: LANE out of range");
    end

    // slope times lane index, kept to 16 bits
    // wrap is intended, the dac code is modular
    dma_cmd_pkg::sample_t lane_offset;

    assign lane_offset = dma_cmd_pkg::sample_t'(slope) * dma_cmd_pkg::sample_t'(LANE);

    // flags
    always_ff @(posedge ps_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else if (advance) begin
            out_valid <= in_valid;
            out_last  <= in_valid && in_last;
        end
    end

    // interpolated sample
    always_ff @(posedge ps_clk) begin
        if (advance) begin
            sample <= base + lane_offset;
        end
    end

    a_valid_known : assert property (
        @(posedge ps_clk) disable iff (!rst_n)
        !$isunknown(out_valid)
    );

endmodule

//--- pwl_cmd_sequencer.sv
`timescale 1ns/1ps
`include "pwl_defines.svh"

module pwl_cmd_sequencer (
    input  wire                    ps_clk,
    input  wire                    rst_n,
    // dma command stream
    input  dma_cmd_pkg::dma_word_t pwl_tdata,
    input  wire                    pwl_tvalid,
    input  wire                    pwl_tlast,
    output logic                   pwl_tready,
    // pipeline stall from the packer
    input  wire                    advance,
    // broadcast to every lane
    output dma_cmd_pkg::sample_t   lane_base,
    output dma_cmd_pkg::slope_t    lane_slope,
    output logic                   lane_valid,
    output logic                   lane_last
);

    dac_out_pkg::gen_state_e state;

    // fields of the incoming word
    dma_cmd_pkg::sample_t cmd_x;
    dma_cmd_pkg::slope_t  cmd_slope;
    dma_cmd_pkg::dt_t     cmd_dt;

    // batches still to go after the one on the output
    dma_cmd_pkg::dt_t     batch_left;
    // tlast of the command being walked
    logic                 cmd_last;
    logic                 last_batch;
    logic                 load;
    logic                 step;
    // base moves by a whole batch worth of slope
    dma_cmd_pkg::sample_t batch_step;

    assign cmd_x     = pwl_tdata[`SAMPLE_WIDTH-1:0];
    assign cmd_slope = pwl_tdata[2*`SAMPLE_WIDTH-1:`SAMPLE_WIDTH];
    assign cmd_dt    = pwl_tdata[`DMA_DATA_WIDTH-1 -: `DT_WIDTH];

    assign last_batch = (batch_left == '0);

    // ready when empty, or when the last batch is leaving this cycle
    assign pwl_tready = (state == dac_out_pkg::IDLE) || (last_batch && advance);

    // zero length commands are taken off the stream but never loaded
    assign load = pwl_tvalid && pwl_tready && (cmd_dt != '0);
    assign step = (state == dac_out_pkg::RUN) && advance && !last_batch;

    assign batch_step = dma_cmd_pkg::sample_t'(lane_slope)
                      * dma_cmd_pkg::sample_t'(`BATCH_SAMPLES);

    // control path
    always_ff @(posedge ps_clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= dac_out_pkg::IDLE;
            lane_valid <= 1'b0;
            lane_last  <= 1'b0;
            cmd_last   <= 1'b0;
            batch_left <= '0;
        end else if (load) begin
            state      <= dac_out_pkg::RUN;
            lane_valid <= 1'b1;
            cmd_last   <= pwl_tlast;
            batch_left <= cmd_dt - 1'b1;
            // single batch command is its own last batch
            lane_last  <= pwl_tlast && (cmd_dt == dma_cmd_pkg::dt_t'(1));
        end else if (step) begin
            batch_left <= batch_left - 1'b1;
            lane_last  <= cmd_last && (batch_left == dma_cmd_pkg::dt_t'(1));
        end else if (state == dac_out_pkg::RUN && advance) begin
            // last batch gone and nothing new to load
            state      <= dac_out_pkg::IDLE;
            lane_valid <= 1'b0;
            lane_last  <= 1'b0;
        end
    end

    // value path
    always_ff @(posedge ps_clk) begin
        if (load) begin
            lane_base  <= cmd_x;
            lane_slope <= cmd_slope;
        end else if (step) begin
            lane_base  <= lane_base + batch_step;
        end
    end

    // nothing goes to the lanes while idle
    a_no_valid_in_idle : assert property (
        @(posedge ps_clk) disable iff (!rst_n)
        (state == dac_out_pkg::IDLE) |-> !lane_valid
    );

endmodule

//--- dac_out_pkg.sv
`include "pwl_defines.svh"

package dac_out_pkg;

    // one DAC batch, sample 0 in the low bits
    typedef logic [`BATCH_SAMPLES*`SAMPLE_WIDTH-1:0] batch_t;

    // sequencer states
    // RUN means a batch is sitting on the lane inputs
    typedef enum logic {
        IDLE = 1'b0,
        RUN  = 1'b1
    } gen_state_e;

endpackage

//--- dma_cmd_pkg.sv
`include "pwl_defines.svh"

package dma_cmd_pkg;

    // raw dac code, wraps modulo 2^16
    typedef logic [`SAMPLE_WIDTH-1:0] sample_t;

    // per-sample increment, two's complement
    typedef logic signed [`SAMPLE_WIDTH-1:0] slope_t;

    // number of batches one command lasts
    typedef logic [`DT_WIDTH-1:0] dt_t;

    // full stream word
    // [47:32] dt, [31:16] slope, [15:0] start value
    typedef logic [`DMA_DATA_WIDTH-1:0] dma_word_t;

endpackage

//--- pwl_defines.svh
`ifndef PWL_DEFINES_SVH
`define PWL_DEFINES_SVH

// samples the DAC takes per clock, one lane each
`define BATCH_SAMPLES 4

// dac sample code width
// also the slope width, slope is signed
`define SAMPLE_WIDTH 16

// duration of one command, counted in batches
`define DT_WIDTH 16

// one stream beat holds one whole command
// layout from msb down: dt, slope, start value
`define DMA_DATA_WIDTH 48

`endif
